// ==== uac_pkg.sv ====
package uac_pkg;

    // data word width, the byte lane logic is built around it
    localparam int DATA_W = 32;

    // byte lanes in one word
    localparam int BYTES_PER_WORD = 4;

    // byte offset inside a word
    localparam int OFFSET_W = 2;

    // sequencer states
    typedef enum logic [2:0] {
        // waiting for a request
        IDLE,
        // offer low word read
        READ_LO,
        // wait for low word data
        WAIT_LO,
        // offer high word read
        READ_HI,
        // wait for high word data
        WAIT_HI,
        // offer low word write
        WRITE_LO,
        // offer high word write
        WRITE_HI,
        // one cycle before idle
        DONE
    } uac_state_t;

endpackage

// ==== uac_request_capture.sv ====
`timescale 1ns/1ps

module uac_request_capture #(
    parameter int ADDR_W = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic [ADDR_W-1:0]             req_addr,
    input  logic [uac_pkg::DATA_W-1:0]    req_wdata,
    input  logic [uac_pkg::DATA_W-1:0]    req_wmask,
    input  logic                          accept,
    input  logic                          release_hold,
    output logic                          req_ready,
    output logic                          hold_write,
    output logic                          hold_aligned,
    output logic                          hold_full,
    output logic [ADDR_W-1:0]             lo_addr,
    output logic [ADDR_W-1:0]             hi_addr,
    output logic [uac_pkg::OFFSET_W-1:0]  hold_offset,
    output logic [uac_pkg::DATA_W-1:0]    hold_wdata,
    output logic [uac_pkg::DATA_W-1:0]    hold_wmask
);
    import uac_pkg::*;

    logic              busy;
    logic              write_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] wmask_q;
    logic              src_write;
    logic [ADDR_W-1:0] src_addr;
    logic [DATA_W-1:0] src_wdata;
    logic [DATA_W-1:0] src_wmask;

    // free while idle, held from accept to release
    assign req_ready = ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (release_hold) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end
    end

    // request fields, taken in the handshake cycle
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            write_q <= req_write;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            wmask_q <= req_wmask;
        end
    end

    // live request while free so the sequencer can pick
    // its first state in the accept cycle
    assign src_write = busy ? write_q : req_write;
    assign src_addr  = busy ? addr_q  : req_addr;
    assign src_wdata = busy ? wdata_q : req_wdata;
    assign src_wmask = busy ? wmask_q : req_wmask;

    assign hold_write   = src_write;
    assign hold_wdata   = src_wdata;
    assign hold_wmask   = src_wmask;
    assign hold_offset  = src_addr[OFFSET_W-1:0];
    // decision flags, derived here only
    assign hold_aligned = (hold_offset == '0);
    assign hold_full    = &src_wmask;

    // aligned word and the one after it
    assign lo_addr = {src_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign hi_addr = lo_addr + ADDR_W'(BYTES_PER_WORD);

endmodule

// ==== uac_access_sequencer.sv ====
`timescale 1ns/1ps

module uac_access_sequencer #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    input  logic              req_ready,
    input  logic              hold_write,
    input  logic              hold_aligned,
    input  logic              hold_full,
    input  logic [ADDR_W-1:0] lo_addr,
    input  logic [ADDR_W-1:0] hi_addr,
    input  logic              mem_ready,
    input  logic              mem_rvalid,
    output logic              accept,
    output logic              release_hold,
    output logic              mem_valid,
    output logic              mem_write,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              capture_lo,
    output logic              capture_hi,
    output logic              sel_hi,
    output logic              load_done
);
    import uac_pkg::*;

    uac_state_t state;
    uac_state_t state_nxt;
    logic       fast_store;
    logic       offer_hi;

    // full aligned store, no read needed
    assign fast_store = hold_write & hold_aligned & hold_full;

    // request handshake, only possible in idle
    assign accept = req_valid & req_ready & (state == IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = fast_store ? WRITE_LO : READ_LO;
                end
            end
            READ_LO: begin
                // held here under back-pressure
                if (mem_ready) begin
                    state_nxt = WAIT_LO;
                end
            end
            WAIT_LO: begin
                if (mem_rvalid) begin
                    if (!hold_aligned) begin
                        state_nxt = READ_HI;
                    end else if (hold_write) begin
                        state_nxt = WRITE_LO;
                    end else begin
                        state_nxt = DONE;
                    end
                end
            end
            READ_HI: begin
                if (mem_ready) begin
                    state_nxt = WAIT_HI;
                end
            end
            WAIT_HI: begin
                // unaligned only, store goes on to write back
                if (mem_rvalid) begin
                    state_nxt = hold_write ? WRITE_LO : DONE;
                end
            end
            WRITE_LO: begin
                if (mem_ready) begin
                    state_nxt = hold_aligned ? DONE : WRITE_HI;
                end
            end
            WRITE_HI: begin
                if (mem_ready) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // memory command, moore outputs stay stable until mem_ready
    assign offer_hi  = (state == READ_HI) || (state == WRITE_HI);
    assign mem_valid = (state == READ_LO) || (state == READ_HI) ||
                       (state == WRITE_LO) || (state == WRITE_HI);
    assign mem_write = (state == WRITE_LO) || (state == WRITE_HI);
    // address is don't care while no command is offered
    assign mem_addr  = offer_hi ? hi_addr : lo_addr;

    // read data strobes into the merge buffers
    assign capture_lo = (state == WAIT_LO) & mem_rvalid;
    assign capture_hi = (state == WAIT_HI) & mem_rvalid;

    // high word write data select
    assign sel_hi = (state == WRITE_HI);

    // last read of a load
    assign load_done = ~hold_write & ((capture_lo & hold_aligned) | capture_hi);

    // frees the capture, req_ready back next cycle
    assign release_hold = (state == DONE);

endmodule

// ==== uac_lane_merge.sv ====
`timescale 1ns/1ps

module uac_lane_merge (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [uac_pkg::DATA_W-1:0]    mem_rdata,
    input  logic                          capture_lo,
    input  logic                          capture_hi,
    input  logic                          sel_hi,
    input  logic                          load_done,
    input  logic                          hold_aligned,
    input  logic [uac_pkg::OFFSET_W-1:0]  hold_offset,
    input  logic [uac_pkg::DATA_W-1:0]    hold_wdata,
    input  logic [uac_pkg::DATA_W-1:0]    hold_wmask,
    output logic [uac_pkg::DATA_W-1:0]    mem_wdata,
    output logic                          resp_valid,
    output logic [uac_pkg::DATA_W-1:0]    resp_rdata
);
    import uac_pkg::*;

    // bits per byte lane
    localparam int BYTE_W = DATA_W / BYTES_PER_WORD;
    // shift amount width, up to one word minus one lane
    localparam int SHIFT_W = $clog2(DATA_W);

    logic [DATA_W-1:0]   lo_buf;
    logic [DATA_W-1:0]   hi_buf;
    logic [SHIFT_W-1:0]  shift_amt;
    logic [2*DATA_W-1:0] old_window;
    logic [2*DATA_W-1:0] wide_data;
    logic [2*DATA_W-1:0] wide_mask;
    logic [2*DATA_W-1:0] new_window;
    logic [2*DATA_W-1:0] rd_window;
    logic [2*DATA_W-1:0] rd_shifted;

    // read word buffers
    always_ff @(posedge clk) begin
        if (rst) begin
            lo_buf <= '0;
            hi_buf <= '0;
        end else begin
            if (capture_lo) begin
                lo_buf <= mem_rdata;
            end
            if (capture_hi) begin
                hi_buf <= mem_rdata;
            end
        end
    end

    // byte offset to bit shift
    assign shift_amt = SHIFT_W'(hold_offset * BYTE_W);

    // store side, 64-bit little endian window
    assign old_window = {hi_buf, lo_buf};
    assign wide_data  = {{DATA_W{1'b0}}, hold_wdata} << shift_amt;
    assign wide_mask  = {{DATA_W{1'b0}}, hold_wmask} << shift_amt;

    // new bit where mask is set, old bit elsewhere
    assign new_window = (old_window & ~wide_mask) | (wide_data & wide_mask);

    // full aligned store: all ones mask, buffer contents drop out
    assign mem_wdata = sel_hi ? new_window[2*DATA_W-1:DATA_W] : new_window[DATA_W-1:0];

    // load side, last word comes live from memory
    // aligned load uses the live word as the low half
    assign rd_window  = {mem_rdata, hold_aligned ? mem_rdata : lo_buf};
    assign rd_shifted = rd_window >> shift_amt;
    assign resp_rdata = rd_shifted[DATA_W-1:0];

    // one cycle pulse with the final read data
    assign resp_valid = load_done;

endmodule

// ==== unaligned_access_top.sv ====
`timescale 1ns/1ps

module unaligned_access_top #(
    parameter int ADDR_W = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    input  logic                       req_write,
    input  logic [ADDR_W-1:0]          req_addr,
    input  logic [uac_pkg::DATA_W-1:0] req_wdata,
    input  logic [uac_pkg::DATA_W-1:0] req_wmask,
    input  logic                       mem_ready,
    input  logic                       mem_rvalid,
    input  logic [uac_pkg::DATA_W-1:0] mem_rdata,
    output logic                       req_ready,
    output logic                       resp_valid,
    output logic [uac_pkg::DATA_W-1:0] resp_rdata,
    output logic                       mem_valid,
    output logic                       mem_write,
    output logic [ADDR_W-1:0]          mem_addr,
    output logic [uac_pkg::DATA_W-1:0] mem_wdata
);
    import uac_pkg::*;

    // capture to sequencer and merge
    logic                hold_write;
    logic                hold_aligned;
    logic                hold_full;
    logic [ADDR_W-1:0]   lo_addr;
    logic [ADDR_W-1:0]   hi_addr;
    logic [OFFSET_W-1:0] hold_offset;
    logic [DATA_W-1:0]   hold_wdata;
    logic [DATA_W-1:0]   hold_wmask;
    // sequencer controls
    logic                accept;
    logic                release_hold;
    logic                capture_lo;
    logic                capture_hi;
    logic                sel_hi;
    logic                load_done;

    uac_request_capture #(
        .ADDR_W (ADDR_W)
    ) u_capture (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_wmask    (req_wmask),
        .accept       (accept),
        .release_hold (release_hold),
        .req_ready    (req_ready),
        .hold_write   (hold_write),
        .hold_aligned (hold_aligned),
        .hold_full    (hold_full),
        .lo_addr      (lo_addr),
        .hi_addr      (hi_addr),
        .hold_offset  (hold_offset),
        .hold_wdata   (hold_wdata),
        .hold_wmask   (hold_wmask)
    );

    uac_access_sequencer #(
        .ADDR_W (ADDR_W)
    ) u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .hold_write   (hold_write),
        .hold_aligned (hold_aligned),
        .hold_full    (hold_full),
        .lo_addr      (lo_addr),
        .hi_addr      (hi_addr),
        .mem_ready    (mem_ready),
        .mem_rvalid   (mem_rvalid),
        .accept       (accept),
        .release_hold (release_hold),
        .mem_valid    (mem_valid),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .capture_lo   (capture_lo),
        .capture_hi   (capture_hi),
        .sel_hi       (sel_hi),
        .load_done    (load_done)
    );

    uac_lane_merge u_merge (
        .clk          (clk),
        .rst          (rst),
        .mem_rdata    (mem_rdata),
        .capture_lo   (capture_lo),
        .capture_hi   (capture_hi),
        .sel_hi       (sel_hi),
        .load_done    (load_done),
        .hold_aligned (hold_aligned),
        .hold_offset  (hold_offset),
        .hold_wdata   (hold_wdata),
        .hold_wmask   (hold_wmask),
        .mem_wdata    (mem_wdata),
        .resp_valid   (resp_valid),
        .resp_rdata   (resp_rdata)
    );

endmodule

// ==== tb_word_memory.sv ====
`timescale 1ns/1ps

module tb_word_memory #(
    parameter int ADDR_W = 32,
    parameter int DEPTH  = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mem_valid,
    input  logic                       mem_write,
    input  logic [ADDR_W-1:0]          mem_addr,
    input  logic [uac_pkg::DATA_W-1:0] mem_wdata,
    output logic                       mem_ready,
    output logic                       mem_rvalid,
    output logic [uac_pkg::DATA_W-1:0] mem_rdata,
    output int                         cmd_count,
    output int                         write_count
);
    import uac_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    int                seed;
    logic [31:0]       rnd_word;
    logic              in_reset;
    logic              fire;
    logic              fire_write;
    logic [IDX_W-1:0]  fire_idx;
    logic [DATA_W-1:0] fire_wdata;
    logic              pending;
    logic [DATA_W-1:0] pending_data;
    int                wait_cnt;

    initial begin
        seed        = 32'h8f9f_a12e;
        mem_ready   = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        cmd_count   = 0;
        write_count = 0;
        pending     = 1'b0;
        wait_cnt    = 0;
        mem[0]      = 32'hcafebebe;
        mem[1]      = 32'hdeadbeef;
        // index pattern, every byte tied to the word number
        for (int i = 2; i < DEPTH; i++) begin
            mem[i] = {i[7:0], ~i[7:0], 8'h5a, 8'(i * 3)};
        end
    end

    // handshake looked at mid cycle, acted on just after the rising edge
    always @(negedge clk) begin
        in_reset   = rst;
        fire       = mem_valid && mem_ready && !rst;
        fire_write = mem_write;
        fire_idx   = mem_addr[IDX_W+1:2];
        fire_wdata = mem_wdata;
        @(posedge clk);
        #1;
        mem_rvalid = 1'b0;
        if (in_reset) begin
            pending = 1'b0;
        end
        if (fire) begin
            cmd_count++;
            if (fire_write) begin
                mem[fire_idx] = fire_wdata;
                write_count++;
            end else begin
                pending      = 1'b1;
                pending_data = mem[fire_idx];
                // extra wait of 0 to 2 cycles
                rnd_word     = $random(seed);
                wait_cnt     = int'(rnd_word[1:0]) % 3;
            end
        end
        // one read in flight at most
        if (pending) begin
            if (wait_cnt == 0) begin
                mem_rvalid = 1'b1;
                mem_rdata  = pending_data;
                pending    = 1'b0;
            end else begin
                wait_cnt--;
            end
        end
        // ready about three cycles in four
        rnd_word  = $random(seed);
        mem_ready = rnd_word[0] | rnd_word[1];
    end

endmodule

// ==== uac_props.sv ====
`timescale 1ns/1ps

module uac_props #(
    parameter int ADDR_W = 32
) (
    input logic                       clk,
    input logic                       rst,
    input logic                       req_ready,
    input logic                       resp_valid,
    input logic                       mem_valid,
    input logic                       mem_ready,
    input logic                       mem_write,
    input logic                       mem_rvalid,
    input logic [ADDR_W-1:0]          mem_addr,
    input logic [uac_pkg::DATA_W-1:0] mem_wdata,
    input uac_pkg::uac_state_t        state
);
    import uac_pkg::*;

    // offered command holds until memory takes it
    cmd_stable: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_write) &&
            $stable(mem_addr) && $stable(mem_wdata))
        else $error("memory command changed before mem_ready");

    // request side only open with no command out
    ready_excl: assert property (@(posedge clk) disable iff (rst)
        !(req_ready && mem_valid))
        else $error("req_ready and mem_valid high together");

    // load data always rides on memory read data
    resp_with_rdata: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> mem_rvalid)
        else $error("resp_valid without mem_rvalid");

    // capture busy flag and sequencer state agree on idle
    ready_in_idle: assert property (@(posedge clk) disable iff (rst)
        req_ready |-> (state == IDLE))
        else $error("req_ready high outside idle");

endmodule

bind unaligned_access_top uac_props #(
    .ADDR_W (ADDR_W)
) u_props (
    .clk        (clk),
    .rst        (rst),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .mem_valid  (mem_valid),
    .mem_ready  (mem_ready),
    .mem_write  (mem_write),
    .mem_rvalid (mem_rvalid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .state      (u_sequencer.state)
);

// ==== tb_unaligned_access.sv ====
`timescale 1ns/1ps

module tb_unaligned_access;

    localparam int ADDR_W       = 32;
    localparam int DEPTH        = 16;
    localparam int N_OPS        = 22;
    localparam int RESET_CYCLES = 8;
    // room for four commands under slow memory per entry
    localparam int TIMEOUT      = RESET_CYCLES + 60 * N_OPS;

    // flags for write, random data and fixed expectation, then the fields
    typedef struct packed {
        logic        wr;
        logic        rnd;
        logic        chk;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] mask;
        logic [31:0] expv;
    } op_t;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [31:0]       req_wdata;
    logic [31:0]       req_wmask;
    logic              req_ready;
    logic              resp_valid;
    logic [31:0]       resp_rdata;
    logic              mem_valid;
    logic              mem_write;
    logic [ADDR_W-1:0] mem_addr;
    logic [31:0]       mem_wdata;
    logic              mem_ready;
    logic              mem_rvalid;
    logic [31:0]       mem_rdata;
    int                cmd_count;
    int                write_count;

    op_t               ops [N_OPS];
    logic [31:0]       shadow [DEPTH];
    int                seed;
    int                cycle_count = 0;

    unaligned_access_top #(
        .ADDR_W (ADDR_W)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .mem_ready  (mem_ready),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    tb_word_memory #(
        .ADDR_W (ADDR_W),
        .DEPTH  (DEPTH)
    ) u_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_valid   (mem_valid),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .cmd_count   (cmd_count),
        .write_count (write_count)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic stop_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expv);
        if (got !== expv) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expv);
            stop_run("run stopped at the first wrong value");
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            stop_run($sformatf("operations still running after %0d cycles", TIMEOUT));
        end
    end

    // window bit 8*offset+b comes from bit b of the access
    function automatic logic [31:0] window_load(input logic [31:0] addr);
        logic [3:0]  idx;
        logic [3:0]  w;
        logic [31:0] res;
        int          pos;
        idx = addr[5:2];
        for (int b = 0; b < 32; b++) begin
            pos    = 8 * int'(addr[1:0]) + b;
            w      = idx + 4'(pos / 32);
            res[b] = shadow[w][pos % 32];
        end
        return res;
    endfunction

    // only bits under the mask move into the window
    function automatic void shadow_store(input logic [31:0] addr, input logic [31:0] data,
                                         input logic [31:0] mask);
        logic [3:0] idx;
        logic [3:0] w;
        int         pos;
        idx = addr[5:2];
        for (int b = 0; b < 32; b++) begin
            pos = 8 * int'(addr[1:0]) + b;
            w   = idx + 4'(pos / 32);
            if (mask[b]) begin
                shadow[w][pos % 32] = data[b];
            end
        end
    endfunction

    function automatic int expected_cmds(input logic wr, input logic [31:0] addr,
                                         input logic [31:0] mask);
        if (addr[1:0] != 2'd0) begin
            return wr ? 4 : 2;
        end
        // full aligned store skips the read
        if (wr && (&mask)) begin
            return 1;
        end
        return wr ? 2 : 1;
    endfunction

    function automatic int expected_writes(input logic wr, input logic [31:0] addr);
        if (!wr) begin
            return 0;
        end
        return (addr[1:0] != 2'd0) ? 2 : 1;
    endfunction

    task automatic compare_memory();
        for (int i = 0; i < DEPTH; i++) begin
            check_value($sformatf("mem[%0d]", i), u_mem.mem[i], shadow[i]);
        end
    endtask

    task automatic fill_table();
        // fixed loads over cafebebe / deadbeef
        ops[0]  = '{1'b0, 1'b0, 1'b1, 32'h00, 32'h0, 32'h0, 32'hcafebebe};
        ops[1]  = '{1'b0, 1'b0, 1'b1, 32'h04, 32'h0, 32'h0, 32'hdeadbeef};
        ops[2]  = '{1'b0, 1'b0, 1'b1, 32'h01, 32'h0, 32'h0, 32'hefcafebe};
        ops[3]  = '{1'b0, 1'b0, 1'b1, 32'h02, 32'h0, 32'h0, 32'hbeefcafe};
        ops[4]  = '{1'b0, 1'b0, 1'b1, 32'h03, 32'h0, 32'h0, 32'hadbeefca};
        // full aligned store then read back
        ops[5]  = '{1'b1, 1'b0, 1'b0, 32'h08, 32'h12345678, 32'hffffffff, 32'h0};
        ops[6]  = '{1'b0, 1'b0, 1'b1, 32'h08, 32'h0, 32'h0, 32'h12345678};
        // partial mask over a known word
        ops[7]  = '{1'b1, 1'b0, 1'b0, 32'h0c, 32'h11223344, 32'hffffffff, 32'h0};
        ops[8]  = '{1'b1, 1'b0, 1'b0, 32'h0c, 32'ha5a5a5a5, 32'h00ff00ff, 32'h0};
        ops[9]  = '{1'b0, 1'b0, 1'b1, 32'h0c, 32'h0, 32'h0, 32'h11a533a5};
        // random unaligned stores at offsets 1 2 3
        ops[10] = '{1'b1, 1'b1, 1'b0, 32'h11, 32'h0, 32'h0, 32'h0};
        ops[11] = '{1'b0, 1'b0, 1'b0, 32'h11, 32'h0, 32'h0, 32'h0};
        ops[12] = '{1'b0, 1'b0, 1'b0, 32'h10, 32'h0, 32'h0, 32'h0};
        ops[13] = '{1'b0, 1'b0, 1'b0, 32'h14, 32'h0, 32'h0, 32'h0};
        ops[14] = '{1'b1, 1'b1, 1'b0, 32'h1a, 32'h0, 32'h0, 32'h0};
        ops[15] = '{1'b0, 1'b0, 1'b0, 32'h1a, 32'h0, 32'h0, 32'h0};
        ops[16] = '{1'b0, 1'b0, 1'b0, 32'h1c, 32'h0, 32'h0, 32'h0};
        ops[17] = '{1'b1, 1'b1, 1'b0, 32'h27, 32'h0, 32'h0, 32'h0};
        ops[18] = '{1'b0, 1'b0, 1'b0, 32'h24, 32'h0, 32'h0, 32'h0};
        ops[19] = '{1'b0, 1'b0, 1'b0, 32'h27, 32'h0, 32'h0, 32'h0};
        // random partial aligned store
        ops[20] = '{1'b1, 1'b1, 1'b0, 32'h30, 32'h0, 32'h0, 32'h0};
        ops[21] = '{1'b0, 1'b0, 1'b0, 32'h30, 32'h0, 32'h0, 32'h0};
    endtask

    task automatic run_op(input int i);
        op_t         op;
        logic [31:0] data;
        logic [31:0] mask;
        logic [31:0] expv;
        int          cmds_before;
        int          writes_before;
        op   = ops[i];
        data = op.data;
        mask = op.mask;
        if (op.rnd) begin
            data = $random(seed);
            mask = $random(seed);
        end
        // bridge idle first
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        cmds_before   = cmd_count;
        writes_before = write_count;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req_write = op.wr;
        req_addr  = op.addr;
        req_wdata = data;
        req_wmask = mask;
        // taken at this edge since req_ready was high
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (op.wr) begin
            shadow_store(op.addr, data, mask);
            @(negedge clk);
            while (!req_ready) begin
                @(negedge clk);
            end
            compare_memory();
        end else begin
            expv = op.chk ? op.expv : window_load(op.addr);
            @(negedge clk);
            while (!resp_valid) begin
                @(negedge clk);
            end
            check_value("resp_rdata", resp_rdata, expv);
        end
        check_value("command count", cmd_count - cmds_before,
                    expected_cmds(op.wr, op.addr, mask));
        check_value("write count", write_count - writes_before,
                    expected_writes(op.wr, op.addr));
    endtask

    initial begin
        seed      = 32'h8f9f_a12e;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wmask = '0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        // shadow starts from the model preload
        for (int i = 0; i < DEPTH; i++) begin
            shadow[i] = u_mem.mem[i];
        end
        @(negedge clk);
        check_value("req_ready", {31'b0, req_ready}, 32'd1);
        check_value("mem_valid", {31'b0, mem_valid}, 32'd0);
        check_value("resp_valid", {31'b0, resp_valid}, 32'd0);
        for (int i = 0; i < N_OPS; i++) begin
            run_op(i);
        end
        compare_memory();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== unaligned_access.f ====
uac_pkg.sv
uac_request_capture.sv
uac_access_sequencer.sv
uac_lane_merge.sv
unaligned_access_top.sv
tb_word_memory.sv
uac_props.sv
tb_unaligned_access.sv

// ==== Makefile ====
TOP := tb_unaligned_access

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f unaligned_access.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f unaligned_access.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
